// ==== files.f ====
source/mem_pkg.sv
source/load_addr_stage.sv
source/load_data_stage.sv
source/store_unit.sv
source/wb_arbiter.sv
source/data_ram.sv
source/mem_subsystem.sv
test/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module mem_subsystem_tb \
    && ./obj_dir/Vmem_subsystem_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic             clock,
    input  logic             reset,
    input  mem_pkg::wb_req_t wb_req,
    output mem_pkg::wb_rsp_t wb_rsp
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    mem_pkg::data_t mem [RAM_WORDS];

    logic             access;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    mem_pkg::data_t   rdata_q;

    // A request counts once; the ack cycle itself is not a new access
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign idx    = IDX_W'(wb_req.adr % 32'(RAM_WORDS));

    always_ff @(posedge clock) begin
        if (access && wb_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (wb_req.sel[i]) begin
                    mem[idx][i*8 +: 8] <= wb_req.dat[i*8 +: 8];
                end
            end
        end
        if (access) begin
            rdata_q <= mem[idx];
        end
    end

    // Single-cycle ack, the cycle after the request
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign wb_rsp = '{
        ack: ack_q,
        dat: rdata_q
    };

endmodule

// ==== source/load_addr_stage.sv ====
`timescale 1ns/1ps

module load_addr_stage (
    input  logic                       clock,
    input  logic                       reset,

    // From execute
    input  mem_pkg::load_addr_packet_t load_addr_packet_in,
    output logic                       load_addr_free,

    // To the data stage
    input  logic                       load_data_free,
    output mem_pkg::load_data_packet_t load_data_packet
);

    mem_pkg::load_addr_packet_t load_addr_packet;

    mem_pkg::data_t      opa;
    mem_pkg::data_t      opb;
    mem_pkg::data_t      addr;
    mem_pkg::mem_size_t  size;
    mem_pkg::byte_mask_t size_byte_mask;

    // Hold a packet only while the data stage is busy
    assign load_addr_free = load_data_free | ~load_addr_packet.valid;

    // Operand A mux
    always_comb begin
        case (load_addr_packet.opa_select)
            mem_pkg::OPA_IS_RS1:  opa = load_addr_packet.source_reg_1;
            mem_pkg::OPA_IS_ZERO: opa = '0;
            default:              opa = '0;
        endcase
    end

    // Operand B mux
    always_comb begin
        case (load_addr_packet.opb_select)
            mem_pkg::OPB_IS_RS2:   opb = load_addr_packet.source_reg_2;
            mem_pkg::OPB_IS_I_IMM: opb = mem_pkg::i_imm(load_addr_packet.inst);
            mem_pkg::OPB_IS_S_IMM: opb = mem_pkg::s_imm(load_addr_packet.inst);
            default:               opb = '0;
        endcase
    end

    assign addr           = opa + opb;
    assign size           = mem_pkg::mem_size_t'(load_addr_packet.inst.r.funct3[1:0]);
    assign size_byte_mask = mem_pkg::size_mask(size);

    assign load_data_packet = '{
        valid:        load_addr_packet.valid,
        dest_reg_idx: load_addr_packet.dest_reg_idx,
        load_addr:    addr,
        byte_mask:    size_byte_mask << addr[1:0],
        size:         size,
        is_unsigned:  load_addr_packet.inst.r.funct3[2]
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            load_addr_packet <= mem_pkg::NOP_LOAD_ADDR_PACKET;
        end else if (load_addr_free) begin
            load_addr_packet <= load_addr_packet_in;
        end
    end

endmodule

// ==== source/load_data_stage.sv ====
`timescale 1ns/1ps

module load_data_stage (
    input  logic                       clock,
    input  logic                       reset,

    // From the address stage
    input  mem_pkg::load_data_packet_t load_data_packet,
    output logic                       load_data_free,

    // Wishbone master port
    output mem_pkg::wb_req_t           wb_req,
    input  mem_pkg::wb_rsp_t           wb_rsp,

    // Result broadcast
    output mem_pkg::load_result_t      load_result
);

    // One load held from accept until ack
    logic                       busy;
    mem_pkg::load_data_packet_t held;

    logic           take;
    logic           done;
    mem_pkg::data_t shifted;
    mem_pkg::data_t extended;

    assign load_data_free = ~busy;
    assign take           = load_data_packet.valid & load_data_free;
    assign done           = busy & wb_rsp.ack;

    assign wb_req = '{
        cyc: busy,
        stb: busy,
        we:  1'b0,
        adr: mem_pkg::word_adr(held.load_addr),
        dat: '0,
        sel: held.byte_mask
    };

    // Move the addressed lanes down to bit 0
    assign shifted = wb_rsp.dat >> {held.load_addr[1:0], 3'b000};

    always_comb begin
        case (held.size)
            mem_pkg::BYTE: begin
                if (held.is_unsigned) begin
                    extended = {24'b0, shifted[7:0]};
                end else begin
                    extended = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            mem_pkg::HALF: begin
                if (held.is_unsigned) begin
                    extended = {16'b0, shifted[15:0]};
                end else begin
                    extended = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: extended = shifted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            held <= load_data_packet;
        end
    end

    // Result is valid for the single cycle after ack
    always_ff @(posedge clock) begin
        if (reset) begin
            load_result <= mem_pkg::NOP_LOAD_RESULT;
        end else begin
            load_result <= '{
                valid:        done,
                dest_reg_idx: held.dest_reg_idx,
                data:         extended
            };
        end
    end

endmodule

// ==== source/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0] data_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [3:0]  byte_mask_t;

    // RV32 instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } inst_t;

    typedef enum logic {
        OPA_IS_RS1  = 1'b0,
        OPA_IS_ZERO = 1'b1
    } opa_select_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2   = 2'h0,
        OPB_IS_I_IMM = 2'h1,
        OPB_IS_S_IMM = 2'h2
    } opb_select_t;

    // Encoded as funct3[1:0]
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_t;

    typedef struct packed {
        logic        valid;
        inst_t       inst;
        opa_select_t opa_select;
        opb_select_t opb_select;
        data_t       source_reg_1;
        data_t       source_reg_2;
        phys_reg_t   dest_reg_idx;
    } load_addr_packet_t;

    typedef struct packed {
        logic       valid;
        phys_reg_t  dest_reg_idx;
        data_t      load_addr;
        byte_mask_t byte_mask;
        mem_size_t  size;
        logic       is_unsigned;
    } load_data_packet_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t dest_reg_idx;
        data_t     data;
    } load_result_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
        data_t base;
        data_t store_data;
    } store_packet_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        data_t      adr;
        data_t      dat;
        byte_mask_t sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    localparam load_addr_packet_t NOP_LOAD_ADDR_PACKET = load_addr_packet_t'(0);
    localparam load_result_t      NOP_LOAD_RESULT      = load_result_t'(0);
    localparam wb_req_t           WB_REQ_IDLE          = wb_req_t'(0);
    localparam wb_rsp_t           WB_RSP_IDLE          = wb_rsp_t'(0);

    function automatic data_t i_imm(inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic data_t s_imm(inst_t inst);
        return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

    // Unshifted lane mask for an access size
    function automatic byte_mask_t size_mask(mem_size_t size);
        case (size)
            BYTE:    return 4'b0001;
            HALF:    return 4'b0011;
            WORD:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    // Byte address to bus word address
    function automatic data_t word_adr(data_t addr);
        return {2'b00, addr[31:2]};
    endfunction

endpackage

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int RAM_WORDS = 256
) (
    input  logic                       clock,
    input  logic                       reset,

    // Load issue
    input  mem_pkg::load_addr_packet_t load_addr_in,
    output logic                       load_addr_free,

    // Store issue
    input  mem_pkg::store_packet_t     store_in,
    output logic                       store_free,

    // Load result broadcast
    output mem_pkg::load_result_t      load_result
);

    mem_pkg::load_data_packet_t load_data_packet;
    logic                       load_data_free;

    mem_pkg::wb_req_t load_req;
    mem_pkg::wb_rsp_t load_rsp;
    mem_pkg::wb_req_t store_req;
    mem_pkg::wb_rsp_t store_rsp;
    mem_pkg::wb_req_t ram_req;
    mem_pkg::wb_rsp_t ram_rsp;

    load_addr_stage i_load_addr_stage (
        .clock               (clock),
        .reset               (reset),
        .load_addr_packet_in (load_addr_in),
        .load_addr_free      (load_addr_free),
        .load_data_free      (load_data_free),
        .load_data_packet    (load_data_packet)
    );

    load_data_stage i_load_data_stage (
        .clock            (clock),
        .reset            (reset),
        .load_data_packet (load_data_packet),
        .load_data_free   (load_data_free),
        .wb_req           (load_req),
        .wb_rsp           (load_rsp),
        .load_result      (load_result)
    );

    store_unit i_store_unit (
        .clock      (clock),
        .reset      (reset),
        .store_in   (store_in),
        .store_free (store_free),
        .wb_req     (store_req),
        .wb_rsp     (store_rsp)
    );

    wb_arbiter i_wb_arbiter (
        .clock     (clock),
        .reset     (reset),
        .load_req  (load_req),
        .store_req (store_req),
        .load_rsp  (load_rsp),
        .store_rsp (store_rsp),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_data_ram (
        .clock  (clock),
        .reset  (reset),
        .wb_req (ram_req),
        .wb_rsp (ram_rsp)
    );

endmodule

// ==== source/store_unit.sv ====
`timescale 1ns/1ps

module store_unit (
    input  logic                   clock,
    input  logic                   reset,

    // From issue
    input  mem_pkg::store_packet_t store_in,
    output logic                   store_free,

    // Wishbone master port
    output mem_pkg::wb_req_t       wb_req,
    input  mem_pkg::wb_rsp_t       wb_rsp
);

    logic take;
    logic busy;

    mem_pkg::data_t      addr;
    mem_pkg::mem_size_t  size;
    mem_pkg::byte_mask_t sel;
    mem_pkg::data_t      lanes;

    // Bus payload, held for the whole cycle
    mem_pkg::data_t      adr_q;
    mem_pkg::data_t      dat_q;
    mem_pkg::byte_mask_t sel_q;

    assign store_free = ~busy;
    assign take       = store_in.valid & store_free;

    assign addr = store_in.base + mem_pkg::s_imm(store_in.inst);
    assign size = mem_pkg::mem_size_t'(store_in.inst.s.funct3[1:0]);
    assign sel  = mem_pkg::size_mask(size) << addr[1:0];

    // Copy the low bits into every lane, sel picks the live ones
    always_comb begin
        case (size)
            mem_pkg::BYTE: lanes = {4{store_in.store_data[7:0]}};
            mem_pkg::HALF: lanes = {2{store_in.store_data[15:0]}};
            default:       lanes = store_in.store_data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
        end else if (busy && wb_rsp.ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            adr_q <= mem_pkg::word_adr(addr);
            dat_q <= lanes;
            sel_q <= sel;
        end
    end

    assign wb_req = '{
        cyc: busy,
        stb: busy,
        we:  1'b1,
        adr: adr_q,
        dat: dat_q,
        sel: sel_q
    };

endmodule

// ==== source/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic             clock,
    input  logic             reset,

    // Master side
    input  mem_pkg::wb_req_t load_req,
    input  mem_pkg::wb_req_t store_req,
    output mem_pkg::wb_rsp_t load_rsp,
    output mem_pkg::wb_rsp_t store_rsp,

    // Slave side
    output mem_pkg::wb_req_t ram_req,
    input  mem_pkg::wb_rsp_t ram_rsp
);

    logic grant_valid_q;
    logic grant_store_q;
    logic grant_valid;
    logic grant_store;
    logic locked;

    // Owner keeps the bus until it drops cyc
    assign locked = grant_valid_q & (grant_store_q ? store_req.cyc : load_req.cyc);

    always_comb begin
        if (locked) begin
            grant_valid = 1'b1;
            grant_store = grant_store_q;
        end else if (load_req.cyc) begin
            // Loads first, they wake dependents
            grant_valid = 1'b1;
            grant_store = 1'b0;
        end else if (store_req.cyc) begin
            grant_valid = 1'b1;
            grant_store = 1'b1;
        end else begin
            grant_valid = 1'b0;
            grant_store = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            grant_valid_q <= 1'b0;
            grant_store_q <= 1'b0;
        end else begin
            grant_valid_q <= grant_valid;
            grant_store_q <= grant_store;
        end
    end

    always_comb begin
        ram_req   = mem_pkg::WB_REQ_IDLE;
        load_rsp  = mem_pkg::WB_RSP_IDLE;
        store_rsp = mem_pkg::WB_RSP_IDLE;
        load_rsp.dat  = ram_rsp.dat;
        store_rsp.dat = ram_rsp.dat;
        if (grant_valid) begin
            ram_req = grant_store ? store_req : load_req;
            load_rsp.ack  = ram_rsp.ack & ~grant_store;
            store_rsp.ack = ram_rsp.ack & grant_store;
        end
    end

endmodule

// ==== test/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int RAM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 60;
    localparam logic [31:0] LANE_WORD = 32'h300;

    logic                       clock = 1'b0;
    logic                       reset = 1'b1;
    mem_pkg::load_addr_packet_t load_addr_in;
    logic                       load_addr_free;
    mem_pkg::store_packet_t     store_in;
    logic                       store_free;
    mem_pkg::load_result_t      load_result;

    // Reference model and bookkeeping
    mem_pkg::data_t        shadow [RAM_WORDS];
    mem_pkg::data_t        addrs [8];
    mem_pkg::load_result_t expected_q [$];
    mem_pkg::load_result_t received_q [$];
    mem_pkg::data_t        rand_state = 32'd3;
    string                 current_test = "startup";
    int checked;
    int checks;
    int errors;
    int protocol_errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    int stall_cycles;

    mem_subsystem #(
        .RAM_WORDS (RAM_WORDS)
    ) i_dut (
        .clock          (clock),
        .reset          (reset),
        .load_addr_in   (load_addr_in),
        .load_addr_free (load_addr_free),
        .store_in       (store_in),
        .store_free     (store_free),
        .load_result    (load_result)
    );

    always #50 clock = ~clock;

    // Collect every broadcast result in arrival order
    always @(posedge clock) begin
        if (!reset && load_result.valid) begin
            received_q.push_back(load_result);
        end
    end

    // CDB broadcast lasts one cycle
    result_single_cycle: assert property (@(posedge clock) disable iff (reset)
        load_result.valid |=> !load_result.valid)
        else begin
            protocol_errors++;
            $display("Load result held valid for two cycles in test %s", current_test);
        end

    function automatic mem_pkg::data_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic mem_pkg::data_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic int shadow_idx(input mem_pkg::data_t addr);
        return int'((addr >> 2) % RAM_WORDS);
    endfunction

    // Value a load must return per RV32 LB/LH/LW/LBU/LHU rules
    function automatic mem_pkg::data_t expected_load(input mem_pkg::data_t addr,
                                                     input logic [2:0] funct3);
        mem_pkg::data_t word;
        word = shadow[shadow_idx(addr)] >> (8 * int'(addr[1:0]));
        case (funct3)
            3'b000:  return {{24{word[7]}}, word[7:0]};
            3'b100:  return {24'h0, word[7:0]};
            3'b001:  return {{16{word[15]}}, word[15:0]};
            3'b101:  return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic update_shadow(input mem_pkg::data_t addr, input logic [2:0] funct3,
                                 input mem_pkg::data_t data);
        int idx;
        int sh;
        idx = shadow_idx(addr);
        sh  = 8 * int'(addr[1:0]);
        case (funct3[1:0])
            2'b00:   shadow[idx][sh +: 8] = data[7:0];
            2'b01:   shadow[idx][sh +: 16] = data[15:0];
            default: shadow[idx] = data;
        endcase
    endtask

    task automatic check_value(input string what, input mem_pkg::data_t exp,
                               input mem_pkg::data_t act);
        assert (act === exp) begin
            checks++;
        end else begin
            errors++;
            $display("[FAIL] %s %s expected %h actual %h", current_test, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in test %s: %s", current_test, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = errors + protocol_errors;
    endtask

    task automatic finish_test();
        if (errors + protocol_errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d failures", current_test,
                     errors + protocol_errors - errors_at_start);
        end
    endtask

    task automatic issue_load(input mem_pkg::opa_select_t opa, input mem_pkg::opb_select_t opb,
                              input logic [2:0] funct3, input logic [11:0] imm,
                              input mem_pkg::data_t rs1, input mem_pkg::data_t rs2,
                              input mem_pkg::phys_reg_t dest);
        mem_pkg::load_addr_packet_t pkt;
        mem_pkg::load_result_t      exp;
        mem_pkg::data_t             a_val;
        mem_pkg::data_t             b_val;
        int cycles;
        pkt               = mem_pkg::NOP_LOAD_ADDR_PACKET;
        pkt.valid         = 1'b1;
        pkt.inst.i.imm    = imm;
        pkt.inst.i.funct3 = funct3;
        pkt.inst.i.opcode = 7'b0000011;
        pkt.opa_select    = opa;
        pkt.opb_select    = opb;
        pkt.source_reg_1  = rs1;
        pkt.source_reg_2  = rs2;
        pkt.dest_reg_idx  = dest;
        a_val = (opa == mem_pkg::OPA_IS_ZERO) ? 32'h0 : rs1;
        b_val = (opb == mem_pkg::OPB_IS_RS2) ? rs2 : sext12(imm);
        exp.valid        = 1'b1;
        exp.dest_reg_idx = dest;
        exp.data         = expected_load(a_val + b_val, funct3);
        load_addr_in = pkt;
        // Free is sampled between edges, where it is stable
        cycles = 0;
        while (!load_addr_free) begin
            stall_cycles++;
            @(posedge clock);
            #1;
            cycles++;
            if (!load_addr_free && cycles >= TIMEOUT_CYCLES) begin
                report_timeout("load never accepted");
            end
        end
        @(posedge clock);
        expected_q.push_back(exp);
        #1;
        load_addr_in = mem_pkg::NOP_LOAD_ADDR_PACKET;
    endtask

    // Returns once store_free is back, so later loads see the write
    task automatic issue_store(input logic [2:0] funct3, input logic [11:0] imm,
                               input mem_pkg::data_t base, input mem_pkg::data_t data);
        mem_pkg::store_packet_t pkt;
        int cycles;
        pkt               = '0;
        pkt.valid         = 1'b1;
        pkt.inst.s.imm_hi = imm[11:5];
        pkt.inst.s.imm_lo = imm[4:0];
        pkt.inst.s.funct3 = funct3;
        pkt.inst.s.opcode = 7'b0100011;
        pkt.base          = base;
        pkt.store_data    = data;
        store_in = pkt;
        cycles = 0;
        while (!store_free) begin
            @(posedge clock);
            #1;
            cycles++;
            if (!store_free && cycles >= TIMEOUT_CYCLES) report_timeout("store never accepted");
        end
        @(posedge clock);
        update_shadow(base + sext12(imm), funct3, data);
        #1;
        store_in = '0;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
            if (!store_free && cycles >= TIMEOUT_CYCLES) report_timeout("store_free stuck low");
        end while (!store_free);
    endtask

    // Wait for all outstanding results, then compare them in issue order
    task automatic drain_results();
        int cycles;
        int i;
        cycles = 0;
        while (received_q.size() < expected_q.size()) begin
            @(posedge clock);
            #1;
            cycles++;
            if (received_q.size() < expected_q.size() && cycles >= TIMEOUT_CYCLES) begin
                report_timeout("load result never arrived");
            end
        end
        // Quiet window to catch duplicated results
        repeat (4) @(posedge clock);
        #1;
        check_value("result count", 32'(expected_q.size()), 32'(received_q.size()));
        for (i = checked; i < expected_q.size() && i < received_q.size(); i++) begin
            check_value("tag", {26'h0, expected_q[i].dest_reg_idx},
                        {26'h0, received_q[i].dest_reg_idx});
            check_value("data", expected_q[i].data, received_q[i].data);
        end
        checked = expected_q.size();
    endtask

    initial begin
        mem_pkg::data_t r;
        mem_pkg::data_t data;
        logic [11:0]    imm;
        int k;
        load_addr_in = mem_pkg::NOP_LOAD_ADDR_PACKET;
        store_in     = '0;
        reset        = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("reset_state");
        @(posedge clock);
        #1;
        check_value("load_result.valid", 32'h0, {31'h0, load_result.valid});
        check_value("load_addr_free", 32'h1, {31'h0, load_addr_free});
        check_value("store_free", 32'h1, {31'h0, store_free});
        finish_test();

        start_test("word_store_load");
        for (k = 0; k < 8; k++) begin
            r = next_rand();
            addrs[k] = {22'h0, 1'b0, r[8:5], k[2:0], 2'b00};
            imm = r[23:12] & 12'hffc;
            issue_store(3'b010, imm, addrs[k] - sext12(imm), next_rand());
            r = next_rand();
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, r[11:0],
                       addrs[k] - sext12(r[11:0]), next_rand(), r[17:12]);
        end
        drain_results();
        finish_test();

        start_test("byte_half_lanes");
        issue_store(3'b010, 12'h0, LANE_WORD, next_rand());
        for (k = 0; k < 4; k++) begin
            issue_store(3'b000, k[11:0], LANE_WORD, next_rand());
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b000, k[11:0],
                       LANE_WORD, 32'h0, 6'd10);
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b100, k[11:0],
                       LANE_WORD, 32'h0, 6'd11);
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, 12'h0,
                       LANE_WORD, 32'h0, 6'd12);
            drain_results();
        end
        for (k = 0; k < 4; k += 2) begin
            issue_store(3'b001, k[11:0], LANE_WORD, next_rand());
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b001, k[11:0],
                       LANE_WORD, 32'h0, 6'd13);
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b101, k[11:0],
                       LANE_WORD, 32'h0, 6'd14);
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, 12'h0,
                       LANE_WORD, 32'h0, 6'd15);
            drain_results();
        end
        finish_test();

        start_test("operand_select");
        issue_load(mem_pkg::OPA_IS_ZERO, mem_pkg::OPB_IS_I_IMM, 3'b010, addrs[2][11:0],
                   next_rand(), next_rand(), 6'd20);
        data = next_rand();
        r = next_rand();
        issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_RS2, 3'b010, r[11:0],
                   data, addrs[3] - data, 6'd21);
        drain_results();
        finish_test();

        start_test("back_to_back");
        stall_cycles = 0;
        for (k = 0; k < 8; k++) begin
            r = next_rand();
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, 12'h0,
                       addrs[r[2:0]], 32'h0, {3'b100, k[2:0]});
        end
        assert (stall_cycles > 0) begin
            checks++;
        end else begin
            errors++;
            $display("No back-pressure seen while loads were issued back to back");
        end
        drain_results();
        finish_test();

        start_test("contention");
        data = next_rand();
        fork
            issue_store(3'b010, 12'h0, addrs[1], data);
            issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, 12'h0,
                       addrs[0], 32'h0, 6'd40);
        join
        issue_load(mem_pkg::OPA_IS_RS1, mem_pkg::OPB_IS_I_IMM, 3'b010, 12'h0,
                   addrs[1], 32'h0, 6'd41);
        drain_results();
        finish_test();

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors + protocol_errors);
        if (errors == 0 && protocol_errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
